// ==== verilog/snn_pkg.sv ====
// spiking core shared definitions
`default_nettype none

package snn_pkg;

	// ------------------------------
	// core sizes
	// ------------------------------
	localparam int NUM_AXONS   = 16;
	localparam int AXON_W      = 4;
	localparam int NUM_NEURONS = 4;
	localparam int WEIGHT_W    = 8;
	localparam int POT_W       = 16;
	// weight index seen by the host, neuron in the upper bits
	localparam int HOST_IDX_W  = AXON_W + 2;

	localparam logic [WEIGHT_W-1:0] WEIGHT_MAX = 8'd255;

	// ------------------------------
	// host bus and address map
	// ------------------------------
	localparam int AXI_ADDR_W = 12;
	localparam int AXI_DATA_W = 32;

	localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL        = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] ADDR_THRESH      = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] ADDR_WEIGHT_BASE = 12'h100;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// time-step phases
	typedef enum logic [2:0] {IDLE, RECALL, FIRE, SAVE, LEARN, FINISH} step_state_t;

endpackage

`default_nettype wire

// ==== verilog/in_spike_buf.sv ====
// input spike buffers
`timescale 1ns/100ps
`default_nettype none

module in_spike_buf (
	input  wire logic                         clk_i,
	input  wire logic                         rst_n_i,
	input  wire logic                         start_i,
	input  wire logic [snn_pkg::NUM_AXONS-1:0] spike_in_i,
	input  wire logic                         save_i,
	input  wire logic [snn_pkg::AXON_W-1:0]    rcl_axon_i,
	input  wire logic                         rcl_rd_i,
	input  wire logic [snn_pkg::AXON_W-1:0]    lrn_axon_i,
	input  wire logic                         lrn_rd_i,
	output logic                              rcl_spike_o,
	output logic                              lrn_spike_o
);
	import snn_pkg::*;

	// recall copy used by the accumulate walk
	logic [NUM_AXONS-1:0] rcl_buf;
	// learn copy, frozen for the update walk
	logic [NUM_AXONS-1:0] lrn_buf;

	// ------------------------------
	// buffer loads
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rcl_buf <= '0;
			lrn_buf <= '0;
		end
		else
		begin
			// new step vector
			if (start_i)
				rcl_buf <= spike_in_i;
			// snapshot for learning
			if (save_i)
				lrn_buf <= rcl_buf;
		end
	end

	// ------------------------------
	// registered bit reads
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rcl_spike_o <= 1'b0;
			lrn_spike_o <= 1'b0;
		end
		else
		begin
			if (rcl_rd_i)
				rcl_spike_o <= rcl_buf[rcl_axon_i];
			if (lrn_rd_i)
				lrn_spike_o <= lrn_buf[lrn_axon_i];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/axon_counter.sv ====
// axon index counter
`timescale 1ns/100ps
`default_nettype none

module axon_counter (
	input  wire logic                      clk_i,
	input  wire logic                      rst_n_i,
	input  wire logic                      clear_i,
	input  wire logic                      en_i,
	output logic [snn_pkg::AXON_W-1:0]     axon_o,
	output logic                           last_o
);
	import snn_pkg::*;

	// ------------------------------
	// index register
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			axon_o <= '0;
		end
		else if (clear_i)
		begin
			axon_o <= '0;
		end
		else if (en_i)
		begin
			// wraps to 0 after the last axon
			axon_o <= axon_o + 1'b1;
		end
	end

	// final axon of the walk
	assign last_o = (axon_o == AXON_W'(NUM_AXONS - 1));

endmodule

`default_nettype wire

// ==== verilog/step_fsm.sv ====
// time-step sequencer
`timescale 1ns/100ps
`default_nettype none

module step_fsm (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire logic start_i,
	input  wire logic learn_en_i,
	input  wire logic last_i,
	output logic      cnt_clear_o,
	output logic      cnt_en_o,
	output logic      rcl_rd_o,
	output logic      lrn_rd_o,
	output logic      save_o,
	output logic      accum_o,
	output logic      fire_o,
	output logic      learn_o,
	output logic      busy_o
);
	import snn_pkg::*;

	step_state_t state;
	step_state_t state_nxt;

	// ------------------------------
	// next state
	// ------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:   if (start_i) state_nxt = RECALL;
			RECALL: if (last_i) state_nxt = FIRE;
			// wait for the last accumulate to land
			FIRE:   if (!accum_o) state_nxt = learn_en_i ? SAVE : FINISH;
			SAVE:   state_nxt = LEARN;
			LEARN:  if (last_i) state_nxt = FINISH;
			FINISH: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state   <= IDLE;
			accum_o <= 1'b0;
			learn_o <= 1'b0;
			busy_o  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// align with the registered spike and row
			accum_o <= rcl_rd_o;
			learn_o <= lrn_rd_o;
			// busy spans the step, drops as IDLE returns
			if (state == IDLE && start_i)
				busy_o <= 1'b1;
			else if (state == FINISH)
				busy_o <= 1'b0;
		end
	end

	// ------------------------------
	// decoded controls
	// ------------------------------
	assign cnt_clear_o = (state == IDLE) || (state == SAVE);
	assign cnt_en_o    = (state == RECALL) || (state == LEARN);
	assign rcl_rd_o    = (state == RECALL);
	assign lrn_rd_o    = (state == LEARN);
	assign save_o      = (state == SAVE);
	// single compare once the pipeline is empty
	assign fire_o      = (state == FIRE) && !accum_o;

endmodule

`default_nettype wire

// ==== verilog/synapse_mem.sv ====
// synapse weight store
`timescale 1ns/100ps
`default_nettype none

module synapse_mem (
	input  wire logic                              clk_i,
	input  wire logic                              rst_n_i,
	input  wire logic [snn_pkg::AXON_W-1:0]         rd_axon_i,
	input  wire logic                              upd_i,
	input  wire logic [snn_pkg::AXON_W-1:0]         upd_axon_i,
	input  wire logic                              upd_spike_i,
	input  wire logic [snn_pkg::NUM_NEURONS-1:0]    fired_i,
	input  wire logic                              host_we_i,
	input  wire logic [snn_pkg::HOST_IDX_W-1:0]     host_idx_i,
	input  wire logic [snn_pkg::WEIGHT_W-1:0]       host_wdata_i,
	output logic [snn_pkg::NUM_NEURONS-1:0][snn_pkg::WEIGHT_W-1:0] row_o,
	output logic [snn_pkg::WEIGHT_W-1:0]            host_rdata_o
);
	import snn_pkg::*;

	logic [WEIGHT_W-1:0] weight [NUM_NEURONS][NUM_AXONS];
	// update index, delayed to meet the registered learn spike
	logic [AXON_W-1:0]   upd_axon_q;

	// ------------------------------
	// recall row read
	// ------------------------------
	always_ff @(posedge clk_i)
	begin
		upd_axon_q <= upd_axon_i;
		for (int n = 0; n < NUM_NEURONS; n++)
			row_o[n] <= weight[n][rd_axon_i];
	end

	// ------------------------------
	// learn update and host write
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int n = 0; n < NUM_NEURONS; n++)
				for (int a = 0; a < NUM_AXONS; a++)
					weight[n][a] <= '0;
		end
		else
		begin
			for (int n = 0; n < NUM_NEURONS; n++)
			begin
				for (int a = 0; a < NUM_AXONS; a++)
				begin
					if (upd_i && upd_spike_i && upd_axon_q == AXON_W'(a))
					begin
						// potentiate on fire, depress otherwise
						if (fired_i[n] && weight[n][a] != WEIGHT_MAX)
							weight[n][a] <= weight[n][a] + 1'b1;
						else if (!fired_i[n] && weight[n][a] != '0)
							weight[n][a] <= weight[n][a] - 1'b1;
					end
					else if (host_we_i && host_idx_i == HOST_IDX_W'(n * NUM_AXONS + a))
					begin
						weight[n][a] <= host_wdata_i;
					end
				end
			end
		end
	end

	// host read, neuron in the upper index bits
	assign host_rdata_o = weight[host_idx_i[HOST_IDX_W-1:AXON_W]][host_idx_i[AXON_W-1:0]];

endmodule

`default_nettype wire

// ==== verilog/neuron_array.sv ====
// neuron membrane array
`timescale 1ns/100ps
`default_nettype none

module neuron_array (
	input  wire logic                                           clk_i,
	input  wire logic                                           rst_n_i,
	input  wire logic                                           accum_i,
	input  wire logic                                           spike_i,
	input  wire logic [snn_pkg::NUM_NEURONS-1:0][snn_pkg::WEIGHT_W-1:0] row_i,
	input  wire logic                                           fire_i,
	input  wire logic [snn_pkg::POT_W-1:0]                      thresh_i,
	output logic [snn_pkg::NUM_NEURONS-1:0]                     fired_o,
	output logic                                                spike_valid_o
);
	import snn_pkg::*;

	logic [POT_W-1:0] pot [NUM_NEURONS];
	// one extra bit catches the carry
	logic [POT_W:0]   sum [NUM_NEURONS];

	always_comb
	begin
		for (int n = 0; n < NUM_NEURONS; n++)
			sum[n] = {1'b0, pot[n]} + {{(POT_W + 1 - WEIGHT_W){1'b0}}, row_i[n]};
	end

	// ------------------------------
	// accumulate and fire
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int n = 0; n < NUM_NEURONS; n++)
				pot[n] <= '0;
			fired_o       <= '0;
			spike_valid_o <= 1'b0;
		end
		else
		begin
			spike_valid_o <= fire_i;
			for (int n = 0; n < NUM_NEURONS; n++)
			begin
				if (fire_i)
				begin
					fired_o[n] <= (pot[n] >= thresh_i);
					// reset on fire, no leak
					if (pot[n] >= thresh_i)
						pot[n] <= '0;
				end
				else if (accum_i && spike_i)
				begin
					// clamp at full scale
					pot[n] <= sum[n][POT_W] ? '1 : sum[n][POT_W-1:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/axi_lite_regs.sv ====
// host register slave
`timescale 1ns/100ps
`default_nettype none

module axi_lite_regs (
	input  wire logic                             clk_i,
	input  wire logic                             rst_n_i,
	input  wire logic [snn_pkg::AXI_ADDR_W-1:0]    awaddr_i,
	input  wire logic                             awvalid_i,
	output logic                                  awready_o,
	input  wire logic [snn_pkg::AXI_DATA_W-1:0]    wdata_i,
	input  wire logic                             wvalid_i,
	output logic                                  wready_o,
	output logic [1:0]                            bresp_o,
	output logic                                  bvalid_o,
	input  wire logic                             bready_i,
	input  wire logic [snn_pkg::AXI_ADDR_W-1:0]    araddr_i,
	input  wire logic                             arvalid_i,
	output logic                                  arready_o,
	output logic [snn_pkg::AXI_DATA_W-1:0]         rdata_o,
	output logic [1:0]                            rresp_o,
	output logic                                  rvalid_o,
	input  wire logic                             rready_i,
	input  wire logic                             busy_i,
	input  wire logic [snn_pkg::WEIGHT_W-1:0]      host_rdata_i,
	output logic                                  learn_en_o,
	output logic [snn_pkg::POT_W-1:0]             thresh_o,
	output logic                                  host_we_o,
	output logic [snn_pkg::HOST_IDX_W-1:0]         host_idx_o,
	output logic [snn_pkg::WEIGHT_W-1:0]           host_wdata_o
);
	import snn_pkg::*;

	logic aw_weight, aw_ctrl, aw_thresh;
	logic ar_weight, ar_ctrl, ar_thresh;
	logic wr_hs, rd_hs;
	logic [AXI_DATA_W-1:0] rd_word;

	// ------------------------------
	// address decode
	// ------------------------------
	// weight window is 0x100..0x1fc, one word per weight
	assign aw_weight = awaddr_i[AXI_ADDR_W-1:HOST_IDX_W+2] ==
		ADDR_WEIGHT_BASE[AXI_ADDR_W-1:HOST_IDX_W+2];
	assign ar_weight = araddr_i[AXI_ADDR_W-1:HOST_IDX_W+2] ==
		ADDR_WEIGHT_BASE[AXI_ADDR_W-1:HOST_IDX_W+2];
	assign aw_ctrl   = (awaddr_i == ADDR_CTRL);
	assign aw_thresh = (awaddr_i == ADDR_THRESH);
	assign ar_ctrl   = (araddr_i == ADDR_CTRL);
	assign ar_thresh = (araddr_i == ADDR_THRESH);

	// addr and data taken together, weights stall while busy
	assign wr_hs = awvalid_i && wvalid_i && !bvalid_o && !(busy_i && aw_weight);
	// a weight write in the same cycle owns the host port
	assign rd_hs = arvalid_i && !rvalid_o && !(busy_i && ar_weight)
		&& !(wr_hs && aw_weight && ar_weight);

	assign awready_o = wr_hs;
	assign wready_o  = wr_hs;
	assign arready_o = rd_hs;

	// ------------------------------
	// weight port
	// ------------------------------
	assign host_we_o    = wr_hs && aw_weight;
	assign host_wdata_o = wdata_i[WEIGHT_W-1:0];
	assign host_idx_o   = host_we_o ? awaddr_i[HOST_IDX_W+1:2] : araddr_i[HOST_IDX_W+1:2];

	// ------------------------------
	// write path
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			learn_en_o <= 1'b0;
			thresh_o   <= '1;
			bvalid_o   <= 1'b0;
			bresp_o    <= RESP_OKAY;
		end
		else
		begin
			if (wr_hs)
			begin
				if (aw_ctrl)
					learn_en_o <= wdata_i[0];
				if (aw_thresh)
					thresh_o <= wdata_i[POT_W-1:0];
				// unmapped writes dropped
				bresp_o  <= (aw_ctrl || aw_thresh || aw_weight) ? RESP_OKAY : RESP_SLVERR;
				bvalid_o <= 1'b1;
			end
			else if (bready_i)
			begin
				bvalid_o <= 1'b0;
			end
		end
	end

	// ------------------------------
	// read path
	// ------------------------------
	always_comb
	begin
		rd_word = '0;
		if (ar_ctrl)
			rd_word[0] = learn_en_o;
		else if (ar_thresh)
			rd_word[POT_W-1:0] = thresh_o;
		else if (ar_weight)
			rd_word[WEIGHT_W-1:0] = host_rdata_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rvalid_o <= 1'b0;
			rresp_o  <= RESP_OKAY;
		end
		else if (rd_hs)
		begin
			rvalid_o <= 1'b1;
			rresp_o  <= (ar_ctrl || ar_thresh || ar_weight) ? RESP_OKAY : RESP_SLVERR;
		end
		else if (rready_i)
		begin
			rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (rd_hs)
			rdata_o <= rd_word;
	end

endmodule

`default_nettype wire

// ==== verilog/snn_core.sv ====
// spiking neural core top
`timescale 1ns/100ps
`default_nettype none

module snn_core (
	input  wire logic                             clk_i,
	input  wire logic                             rst_n_i,
	input  wire logic                             start_i,
	input  wire logic [snn_pkg::NUM_AXONS-1:0]     spike_in_i,
	output logic                                  busy_o,
	output logic                                  spike_valid_o,
	output logic [snn_pkg::NUM_NEURONS-1:0]        fired_o,
	input  wire logic [snn_pkg::AXI_ADDR_W-1:0]    awaddr_i,
	input  wire logic                             awvalid_i,
	output logic                                  awready_o,
	input  wire logic [snn_pkg::AXI_DATA_W-1:0]    wdata_i,
	input  wire logic                             wvalid_i,
	output logic                                  wready_o,
	output logic [1:0]                            bresp_o,
	output logic                                  bvalid_o,
	input  wire logic                             bready_i,
	input  wire logic [snn_pkg::AXI_ADDR_W-1:0]    araddr_i,
	input  wire logic                             arvalid_i,
	output logic                                  arready_o,
	output logic [snn_pkg::AXI_DATA_W-1:0]         rdata_o,
	output logic [1:0]                            rresp_o,
	output logic                                  rvalid_o,
	input  wire logic                             rready_i
);
	import snn_pkg::*;

	// ------------------------------
	// internal nets
	// ------------------------------
	logic                 load;
	logic                 cnt_clear, cnt_en, last;
	logic [AXON_W-1:0]    axon;
	logic                 rcl_rd, lrn_rd, save, accum, fire, learn;
	logic                 rcl_spike, lrn_spike;
	logic [NUM_NEURONS-1:0][WEIGHT_W-1:0] row;
	logic                 learn_en;
	logic [POT_W-1:0]     thresh;
	logic                 host_we;
	logic [HOST_IDX_W-1:0] host_idx;
	logic [WEIGHT_W-1:0]  host_wdata, host_rdata;

	// vector latched only when the sequencer is idle
	assign load = start_i && !busy_o;

	in_spike_buf u_buf (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(load), .spike_in_i(spike_in_i),
		.save_i(save), .rcl_axon_i(axon), .rcl_rd_i(rcl_rd), .lrn_axon_i(axon),
		.lrn_rd_i(lrn_rd), .rcl_spike_o(rcl_spike), .lrn_spike_o(lrn_spike)
	);

	axon_counter u_cnt (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .clear_i(cnt_clear), .en_i(cnt_en),
		.axon_o(axon), .last_o(last)
	);

	step_fsm u_fsm (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_i), .learn_en_i(learn_en),
		.last_i(last), .cnt_clear_o(cnt_clear), .cnt_en_o(cnt_en), .rcl_rd_o(rcl_rd),
		.lrn_rd_o(lrn_rd), .save_o(save), .accum_o(accum), .fire_o(fire),
		.learn_o(learn), .busy_o(busy_o)
	);

	synapse_mem u_syn (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .rd_axon_i(axon), .upd_i(learn),
		.upd_axon_i(axon), .upd_spike_i(lrn_spike), .fired_i(fired_o),
		.host_we_i(host_we), .host_idx_i(host_idx), .host_wdata_i(host_wdata),
		.row_o(row), .host_rdata_o(host_rdata)
	);

	neuron_array u_neu (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .accum_i(accum), .spike_i(rcl_spike),
		.row_i(row), .fire_i(fire), .thresh_i(thresh), .fired_o(fired_o),
		.spike_valid_o(spike_valid_o)
	);

	axi_lite_regs u_regs (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
		.busy_i(busy_o), .host_rdata_i(host_rdata), .learn_en_o(learn_en),
		.thresh_o(thresh), .host_we_o(host_we), .host_idx_o(host_idx),
		.host_wdata_o(host_wdata)
	);

endmodule

`default_nettype wire

// ==== tb/tb_snn_core.sv ====
// spiking core testbench
`timescale 1ns/100ps
`default_nettype none

module tb_snn_core;
	import snn_pkg::*;

	// cycles allowed for any single wait
	localparam int TIMEOUT = 200;

	// ------------------------------
	// DUT signals
	// ------------------------------
	logic                   clk_i;
	logic                   rst_n_i;
	logic                   start_i;
	logic [NUM_AXONS-1:0]   spike_in_i;
	logic                   busy_o;
	logic                   spike_valid_o;
	logic [NUM_NEURONS-1:0] fired_o;
	logic [AXI_ADDR_W-1:0]  awaddr_i;
	logic                   awvalid_i;
	logic                   awready_o;
	logic [AXI_DATA_W-1:0]  wdata_i;
	logic                   wvalid_i;
	logic                   wready_o;
	logic [1:0]             bresp_o;
	logic                   bvalid_o;
	logic                   bready_i;
	logic [AXI_ADDR_W-1:0]  araddr_i;
	logic                   arvalid_i;
	logic                   arready_o;
	logic [AXI_DATA_W-1:0]  rdata_o;
	logic [1:0]             rresp_o;
	logic                   rvalid_o;
	logic                   rready_i;

	// stimulus state
	logic [31:0] lfsr_q;
	// bus state at the last write handshake
	int          wr_wait_cycles;
	logic        wr_busy_at_hs;

	// reference model state
	logic [WEIGHT_W-1:0] m_w [NUM_NEURONS][NUM_AXONS];
	logic [POT_W-1:0]    m_pot [NUM_NEURONS];
	logic [POT_W-1:0]    m_thresh;
	logic                m_learn;

	snn_core uut (.*);

	// 10 ns clock
	always #5 clk_i = ~clk_i;

	// ------------------------------
	// random numbers
	// ------------------------------
	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic [AXI_ADDR_W-1:0] weight_addr(input int n, input int a);
		return ADDR_WEIGHT_BASE + AXI_ADDR_W'(4 * (n * NUM_AXONS + a));
	endfunction

	// ------------------------------
	// failure reporting
	// ------------------------------
	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
		abort_run();
	endtask

	task automatic check_word(input logic [AXI_DATA_W-1:0] got, input logic [AXI_DATA_W-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s response is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_fired(input logic [NUM_NEURONS-1:0] got,
		input logic [NUM_NEURONS-1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// ------------------------------
	// bus tasks
	// ------------------------------
	// back to the drive point just after the rising edge
	task automatic tick();
		@(posedge clk_i);
		#1;
	endtask

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
		input logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
		int   cnt;
		logic hs;
		awaddr_i  = addr;
		wdata_i   = data;
		awvalid_i = 1'b1;
		wvalid_i  = 1'b1;
		cnt = 0;
		hs  = 1'b0;
		while (!hs)
		begin
			@(negedge clk_i);
			if (awready_o && wready_o)
			begin
				hs = 1'b1;
				wr_busy_at_hs  = busy_o;
				wr_wait_cycles = cnt;
			end
			else if (cnt == TIMEOUT)
				report_timeout("write address and data handshake");
			else
				cnt++;
		end
		tick();
		awvalid_i = 1'b0;
		wvalid_i  = 1'b0;
		bready_i  = 1'b1;
		cnt = 0;
		hs  = 1'b0;
		while (!hs)
		begin
			@(negedge clk_i);
			if (bvalid_o)
			begin
				hs = 1'b1;
				resp = bresp_o;
			end
			else if (cnt == TIMEOUT)
				report_timeout("write response");
			else
				cnt++;
		end
		tick();
		bready_i = 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
		output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
		int   cnt;
		logic hs;
		araddr_i  = addr;
		arvalid_i = 1'b1;
		cnt = 0;
		hs  = 1'b0;
		while (!hs)
		begin
			@(negedge clk_i);
			if (arready_o)
				hs = 1'b1;
			else if (cnt == TIMEOUT)
				report_timeout("read address handshake");
			else
				cnt++;
		end
		tick();
		arvalid_i = 1'b0;
		rready_i  = 1'b1;
		cnt = 0;
		hs  = 1'b0;
		while (!hs)
		begin
			@(negedge clk_i);
			if (rvalid_o)
			begin
				hs = 1'b1;
				data = rdata_o;
				resp = rresp_o;
			end
			else if (cnt == TIMEOUT)
				report_timeout("read data");
			else
				cnt++;
		end
		tick();
		rready_i = 1'b0;
	endtask

	task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_resp(resp, RESP_OKAY, $sformatf("write 0x%03h", addr));
	endtask

	task automatic read_expect(input logic [AXI_ADDR_W-1:0] addr,
		input logic [AXI_DATA_W-1:0] exp, input string what);
		logic [AXI_DATA_W-1:0] data;
		logic [1:0]            resp;
		axi_read(addr, data, resp);
		check_resp(resp, RESP_OKAY, what);
		check_word(data, exp, what);
	endtask

	task automatic set_thresh(input logic [POT_W-1:0] value);
		write_reg(ADDR_THRESH, AXI_DATA_W'(value));
		m_thresh = value;
	endtask

	// same weight on one axon for every neuron
	task automatic set_axon_weights(input int a, input logic [WEIGHT_W-1:0] value);
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			write_reg(weight_addr(n, a), AXI_DATA_W'(value));
			m_w[n][a] = value;
		end
	endtask

	task automatic read_all_weights();
		for (int n = 0; n < NUM_NEURONS; n++)
			for (int a = 0; a < NUM_AXONS; a++)
				read_expect(weight_addr(n, a), AXI_DATA_W'(m_w[n][a]),
					$sformatf("weight n%0d a%0d", n, a));
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	task automatic model_step(input logic [NUM_AXONS-1:0] spikes,
		output logic [NUM_NEURONS-1:0] fired);
		int sum;
		fired = '0;
		// accumulate with clamp at full scale
		for (int a = 0; a < NUM_AXONS; a++)
			if (spikes[a])
				for (int n = 0; n < NUM_NEURONS; n++)
				begin
					sum = int'(m_pot[n]) + int'(m_w[n][a]);
					if (sum > 2 ** POT_W - 1)
						m_pot[n] = '1;
					else
						m_pot[n] = sum[POT_W-1:0];
				end
		// fire and clear
		for (int n = 0; n < NUM_NEURONS; n++)
			if (m_pot[n] >= m_thresh)
			begin
				fired[n] = 1'b1;
				m_pot[n] = '0;
			end
		// plus or minus one on spiked axons with clamps at 0 and 255
		if (m_learn)
			for (int a = 0; a < NUM_AXONS; a++)
				if (spikes[a])
					for (int n = 0; n < NUM_NEURONS; n++)
						if (fired[n] && m_w[n][a] != 2 ** WEIGHT_W - 1)
							m_w[n][a] = m_w[n][a] + 8'd1;
						else if (!fired[n] && m_w[n][a] != 0)
							m_w[n][a] = m_w[n][a] - 8'd1;
	endtask

	// ------------------------------
	// time step tasks
	// ------------------------------
	task automatic launch_step(input logic [NUM_AXONS-1:0] spikes);
		spike_in_i = spikes;
		start_i    = 1'b1;
		tick();
		start_i = 1'b0;
	endtask

	// counts valid pulses until busy_o drops
	task automatic wait_step(output int n_valid, output logic [NUM_NEURONS-1:0] fired);
		int   cnt;
		logic done;
		n_valid = 0;
		fired   = '0;
		cnt  = 0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk_i);
			if (spike_valid_o)
			begin
				n_valid++;
				fired = fired_o;
			end
			if (!busy_o)
				done = 1'b1;
			else if (cnt == TIMEOUT)
				report_timeout("end of time step");
			else
				cnt++;
		end
		tick();
	endtask

	task automatic finish_step(input logic [NUM_NEURONS-1:0] exp);
		int                     n_valid;
		logic [NUM_NEURONS-1:0] got;
		wait_step(n_valid, got);
		check_word(AXI_DATA_W'(n_valid), 1, "spike_valid_o pulse count");
		check_fired(got, exp, "fired_o at spike_valid_o");
		// holds until the next fire
		check_fired(fired_o, exp, "fired_o after step");
	endtask

	task automatic run_step(input logic [NUM_AXONS-1:0] spikes);
		logic [NUM_NEURONS-1:0] exp;
		model_step(spikes, exp);
		launch_step(spikes);
		finish_step(exp);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		logic [AXI_DATA_W-1:0]  data;
		logic [1:0]             resp;
		logic [NUM_AXONS-1:0]   spikes;
		logic [NUM_NEURONS-1:0] exp_fired;
		logic [WEIGHT_W-1:0]    w;
		clk_i      = 1'b0;
		rst_n_i    = 1'b0;
		start_i    = 1'b0;
		spike_in_i = '0;
		awaddr_i   = '0;
		awvalid_i  = 1'b0;
		wdata_i    = '0;
		wvalid_i   = 1'b0;
		bready_i   = 1'b0;
		araddr_i   = '0;
		arvalid_i  = 1'b0;
		rready_i   = 1'b0;
		lfsr_q     = 32'h84ec;
		wr_wait_cycles = 0;
		wr_busy_at_hs  = 1'b0;
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			m_pot[n] = '0;
			for (int a = 0; a < NUM_AXONS; a++)
				m_w[n][a] = '0;
		end
		m_thresh = '1;
		m_learn  = 1'b0;
		repeat (16) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		tick();

		// reset state
		check_word(AXI_DATA_W'(busy_o), 0, "busy_o after reset");
		check_word(AXI_DATA_W'(spike_valid_o), 0, "spike_valid_o after reset");
		check_word(AXI_DATA_W'(bvalid_o), 0, "bvalid_o after reset");
		check_word(AXI_DATA_W'(rvalid_o), 0, "rvalid_o after reset");
		check_word(AXI_DATA_W'(awready_o), 0, "awready_o after reset");
		check_word(AXI_DATA_W'(wready_o), 0, "wready_o after reset");
		check_word(AXI_DATA_W'(arready_o), 0, "arready_o after reset");
		check_fired(fired_o, '0, "fired_o after reset");
		read_expect(ADDR_THRESH, 32'h0000_ffff, "threshold after reset");
		read_expect(ADDR_CTRL, 32'h0, "control after reset");

		// random weights and threshold read back
		for (int n = 0; n < NUM_NEURONS; n++)
			for (int a = 0; a < NUM_AXONS; a++)
			begin
				w = WEIGHT_W'(rand_bits(WEIGHT_W));
				write_reg(weight_addr(n, a), AXI_DATA_W'(w));
				m_w[n][a] = w;
			end
		set_thresh(POT_W'(500 + rand_bits(11)));
		read_all_weights();
		read_expect(ADDR_THRESH, AXI_DATA_W'(m_thresh), "threshold");
		read_expect(ADDR_CTRL, 32'h0, "control");
		// unmapped space
		axi_write(12'h008, 32'hffff_ffff, resp);
		check_resp(resp, RESP_SLVERR, "unmapped write");
		axi_read(12'h200, data, resp);
		check_resp(resp, RESP_SLVERR, "unmapped read");
		check_word(data, 32'h0, "unmapped read data");
		read_expect(ADDR_THRESH, AXI_DATA_W'(m_thresh), "threshold after unmapped write");

		// inference only with potentials carried over
		repeat (20)
			run_step(NUM_AXONS'(rand_bits(NUM_AXONS)));

		// learning on
		write_reg(ADDR_CTRL, 32'h1);
		m_learn = 1'b1;
		read_expect(ADDR_CTRL, 32'h1, "control with learning");
		// all neurons fire to reach the top limit
		set_axon_weights(3, 8'd255);
		set_axon_weights(9, 8'd255);
		set_thresh('0);
		run_step('1);
		// weights pinned at 255 must not wrap
		read_all_weights();
		// no neuron fires to reach the bottom limit
		set_axon_weights(3, 8'd0);
		set_axon_weights(9, 8'd0);
		set_thresh('1);
		run_step('1);
		read_all_weights();
		set_thresh(POT_W'(500 + rand_bits(11)));
		repeat (4)
			run_step(NUM_AXONS'(rand_bits(NUM_AXONS)));
		read_all_weights();

		// weight write stalled by a running step
		write_reg(ADDR_CTRL, 32'h0);
		m_learn = 1'b0;
		set_thresh(POT_W'(500 + rand_bits(11)));
		spikes = NUM_AXONS'(rand_bits(NUM_AXONS));
		w = WEIGHT_W'(rand_bits(WEIGHT_W));
		model_step(spikes, exp_fired);
		launch_step(spikes);
		fork
			finish_step(exp_fired);
			axi_write(weight_addr(2, 7), AXI_DATA_W'(w), resp);
		join
		m_w[2][7] = w;
		check_resp(resp, RESP_OKAY, "stalled weight write");
		check_word(AXI_DATA_W'(wr_busy_at_hs), 0, "busy_o at stalled write handshake");
		check_word(AXI_DATA_W'(wr_wait_cycles > 0), 1, "weight write held off during step");
		read_expect(weight_addr(2, 7), AXI_DATA_W'(w), "weight after stalled write");
		run_step(NUM_AXONS'(rand_bits(NUM_AXONS)));

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/snn_pkg.sv
verilog/in_spike_buf.sv
verilog/axon_counter.sv
verilog/step_fsm.sv
verilog/synapse_mem.sv
verilog/neuron_array.sv
verilog/axi_lite_regs.sv
verilog/snn_core.sv
tb/tb_snn_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_snn_core --Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_snn_core
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0
